//--- Makefile
SRCS := $(shell cat list.f)

obj_dir/Vtb_cache: list.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_cache -f list.f

run: obj_dir/Vtb_cache
	@out=$$(./obj_dir/Vtb_cache); echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 lk_valid,
	input  logic                 lk_write,
	input  cache_pkg::addr_t     lk_addr,
	input  cache_pkg::word_t     lk_wdata,
	input  logic                 lk_hit,
	input  cache_pkg::word_t     drd_data,
	input  logic                 mem_rvalid,
	input  cache_pkg::word_t     mem_rdata,
	output logic                 lk_take,
	output logic                 upd_en,
	output cache_pkg::index_t    upd_index,
	output cache_pkg::tag_t      upd_tag,
	output cache_pkg::offset_t   upd_offset,
	output logic                 dwr_en,
	output cache_pkg::index_t    dwr_index,
	output cache_pkg::offset_t   dwr_offset,
	output cache_pkg::word_t     dwr_data,
	output logic                 mem_rd,
	output logic                 mem_wr,
	output cache_pkg::mem_addr_t mem_addr,
	output cache_pkg::word_t     mem_wdata,
	output logic                 rsp_valid,
	output cache_pkg::word_t     rsp_data,
	output logic                 rsp_hit
);
	import cache_pkg::*;

	ctrl_state_t state;

	addr_t cur_addr; // item taken from lookup
	word_t cur_data; // write data, hit data or fill data
	logic  hit_rsp;
	logic  cache_upd;

	assign lk_take   = (state == IDLE) && lk_valid;
	assign cache_upd = (state == WRITE) || (state == FILL);

	assign upd_en     = cache_upd;
	assign upd_index  = addr_index(cur_addr);
	assign upd_tag    = addr_tag(cur_addr);
	assign upd_offset = addr_offset(cur_addr);

	assign dwr_en     = cache_upd;
	assign dwr_index  = addr_index(cur_addr);
	assign dwr_offset = addr_offset(cur_addr);
	assign dwr_data   = cur_data;

	assign mem_wr    = (state == WRITE); // write-through
	assign mem_addr  = addr_word(cur_addr);
	assign mem_wdata = cur_data;

	// hit answers from a register, miss answers during FILL
	assign rsp_valid = hit_rsp || (state == FILL);
	assign rsp_data  = cur_data;
	assign rsp_hit   = hit_rsp;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= IDLE;
			hit_rsp <= 1'b0;
			mem_rd  <= 1'b0;
		end else begin
			hit_rsp <= 1'b0;
			mem_rd  <= 1'b0;
			unique case (state)
				IDLE: begin
					if (lk_valid) begin
						if (lk_write) begin
							state <= WRITE;
						end else if (lk_hit) begin
							hit_rsp <= 1'b1;
						end else begin
							mem_rd <= 1'b1; // single strobe
							state  <= MISS_WAIT;
						end
					end
				end
				WRITE: begin
					state <= IDLE;
				end
				MISS_WAIT: begin
					if (mem_rvalid) begin
						state <= FILL;
					end
				end
				FILL: begin
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (lk_take) begin
			cur_addr <= lk_addr;
			cur_data <= lk_write ? lk_wdata : drd_data;
		end else if ((state == MISS_WAIT) && mem_rvalid) begin
			cur_data <= mem_rdata;
		end
	end

endmodule

`default_nettype wire

//--- cache_data_store.sv
`timescale 1ns/1ps
`default_nettype none

module cache_data_store (
	input  logic               clk,
	input  logic               dwr_en,
	input  cache_pkg::index_t  dwr_index,
	input  cache_pkg::offset_t dwr_offset,
	input  cache_pkg::word_t   dwr_data,
	input  cache_pkg::addr_t   rd_addr,
	output cache_pkg::word_t   drd_data
);
	import cache_pkg::*;

	index_t  rd_index;
	offset_t rd_offset;
	word_t   bank_rd [WORDS];

	assign rd_index  = addr_index(rd_addr);
	assign rd_offset = addr_offset(rd_addr);

	// one bank per word position in the line
	for (genvar b = 0; b < WORDS; b++) begin : g_bank
		word_t bank [LINES];
		logic  bank_we;

		assign bank_we = dwr_en && (dwr_offset == offset_t'(b));

		always_ff @(posedge clk) begin
			if (bank_we) begin
				bank[dwr_index] <= dwr_data;
			end
		end

		assign bank_rd[b] = bank[rd_index]; // whole line read out
	end

	assign drd_data = bank_rd[rd_offset];

endmodule

`default_nettype wire

//--- cache_pkg.sv
`default_nettype none

package cache_pkg;

	typedef logic [11:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [4:0]  tag_t;
	typedef logic [2:0]  index_t;
	typedef logic [1:0]  offset_t;
	typedef logic [9:0]  mem_addr_t;

	typedef enum logic [1:0] {
		IDLE,
		WRITE,
		MISS_WAIT,
		FILL
	} ctrl_state_t;

	localparam int LINES       = 8;
	localparam int WORDS       = 4;
	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
	localparam int MEM_LATENCY = 3;
	localparam int MEM_WORDS   = 1024;

	// address fields: index 11..9, tag 8..4, word 3..2
	function automatic index_t addr_index(input addr_t a);
		return a[11:9];
	endfunction

	function automatic tag_t addr_tag(input addr_t a);
		return a[8:4];
	endfunction

	function automatic offset_t addr_offset(input addr_t a);
		return a[3:2];
	endfunction

	function automatic mem_addr_t addr_word(input addr_t a);
		return a[11:2]; // byte bits dropped
	endfunction

endpackage

`default_nettype wire

//--- cache_properties.sv
`timescale 1ns/1ps
`default_nettype none

module cache_properties (
	input logic                   clk,
	input logic                   arst_n,
	input logic                   rsp_valid,
	input logic                   req_credit,
	input logic                   mem_rd,
	input logic                   mem_wr,
	input cache_pkg::ctrl_state_t state
);
	import cache_pkg::*;

	int unsigned assert_fails = 0; // read by the testbench at the end

	a_quiet_after_reset: assert property (@(posedge clk)
		$rose(arst_n) |-> !(rsp_valid || req_credit || mem_rd || mem_wr))
	else begin
		$error("DUT output active in the first cycle after reset");
		assert_fails++;
	end

	a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		!(mem_rd && mem_wr))
	else begin
		$error("memory read and write strobes high together");
		assert_fails++;
	end

	a_no_rsp_in_write: assert property (@(posedge clk) disable iff (!arst_n)
		(state == WRITE) |-> !rsp_valid)
	else begin
		$error("response raised while the controller is in WRITE");
		assert_fails++;
	end

endmodule

`default_nettype wire

//--- cache_req_queue.sv
`timescale 1ns/1ps
`default_nettype none

module cache_req_queue (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             req_valid,
	input  logic             req_write,
	input  cache_pkg::addr_t req_addr,
	input  cache_pkg::word_t req_wdata,
	input  logic             q_pop,
	output logic             req_credit,
	output logic             q_valid,
	output logic             q_write,
	output cache_pkg::addr_t q_addr,
	output cache_pkg::word_t q_wdata
);
	import cache_pkg::*;

	logic  fifo_write [QUEUE_DEPTH];
	addr_t fifo_addr  [QUEUE_DEPTH];
	word_t fifo_wdata [QUEUE_DEPTH];

	logic [QUEUE_PTR_W-1:0] wr_ptr;
	logic [QUEUE_PTR_W-1:0] rd_ptr;
	logic [QUEUE_PTR_W:0]   count;

	logic push;
	logic pop;

	assign push = req_valid; // requester only sends with credit in hand
	assign pop  = q_pop && q_valid;

	assign q_valid    = (count != '0);
	assign q_write    = fifo_write[rd_ptr];
	assign q_addr     = fifo_addr[rd_ptr];
	assign q_wdata    = fifo_wdata[rd_ptr];
	assign req_credit = pop; // freed slot goes straight back

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			unique case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			fifo_write[wr_ptr] <= req_write;
			fifo_addr[wr_ptr]  <= req_addr;
			fifo_wdata[wr_ptr] <= req_wdata;
		end
	end

endmodule

`default_nettype wire

//--- cache_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tag_store (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               q_valid,
	input  logic               q_write,
	input  cache_pkg::addr_t   q_addr,
	input  cache_pkg::word_t   q_wdata,
	input  logic               lk_take,
	input  logic               upd_en,
	input  cache_pkg::index_t  upd_index,
	input  cache_pkg::tag_t    upd_tag,
	input  cache_pkg::offset_t upd_offset,
	output logic               q_pop,
	output logic               lk_valid,
	output logic               lk_write,
	output cache_pkg::addr_t   lk_addr,
	output cache_pkg::word_t   lk_wdata,
	output logic               lk_hit
);
	import cache_pkg::*;

	tag_t             tag_array  [LINES];
	logic [WORDS-1:0] word_valid [LINES];

	index_t  lk_index;
	offset_t lk_offset;
	logic    load;

	// register free or being handed off this cycle
	assign q_pop = !lk_valid || lk_take;
	assign load  = q_pop && q_valid;

	assign lk_index  = addr_index(lk_addr);
	assign lk_offset = addr_offset(lk_addr);
	assign lk_hit    = lk_valid && word_valid[lk_index][lk_offset]
			&& (tag_array[lk_index] == addr_tag(lk_addr));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			lk_valid <= 1'b0;
		end else if (q_pop) begin
			lk_valid <= q_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			lk_write <= q_write;
			lk_addr  <= q_addr;
			lk_wdata <= q_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (upd_en) begin
			tag_array[upd_index] <= upd_tag;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			word_valid <= '{default: '0};
		end else if (upd_en) begin
			if (tag_array[upd_index] != upd_tag) begin
				word_valid[upd_index] <= WORDS'(1) << upd_offset; // new tag, drop siblings
			end else begin
				word_valid[upd_index][upd_offset] <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             req_valid,
	input  logic             req_write,
	input  cache_pkg::addr_t req_addr,
	input  cache_pkg::word_t req_wdata,
	output logic             req_credit,
	output logic             rsp_valid,
	output cache_pkg::word_t rsp_data,
	output logic             rsp_hit
);
	import cache_pkg::*;

	logic  q_valid;
	logic  q_write;
	addr_t q_addr;
	word_t q_wdata;
	logic  q_pop;

	logic  lk_valid;
	logic  lk_write;
	addr_t lk_addr;
	word_t lk_wdata;
	logic  lk_hit;
	logic  lk_take;

	logic    upd_en;
	index_t  upd_index;
	tag_t    upd_tag;
	offset_t upd_offset;

	logic    dwr_en;
	index_t  dwr_index;
	offset_t dwr_offset;
	word_t   dwr_data;
	word_t   drd_data;

	logic      mem_rd;
	logic      mem_wr;
	mem_addr_t mem_addr;
	word_t     mem_wdata;
	logic      mem_rvalid;
	word_t     mem_rdata;

	cache_req_queue req_queue_i (
		.clk, .arst_n, .req_valid, .req_write, .req_addr, .req_wdata, .q_pop,
		.req_credit, .q_valid, .q_write, .q_addr, .q_wdata
	);

	cache_tag_store tag_store_i (
		.clk, .arst_n, .q_valid, .q_write, .q_addr, .q_wdata, .lk_take,
		.upd_en, .upd_index, .upd_tag, .upd_offset,
		.q_pop, .lk_valid, .lk_write, .lk_addr, .lk_wdata, .lk_hit
	);

	cache_data_store data_store_i (
		.clk, .dwr_en, .dwr_index, .dwr_offset, .dwr_data,
		.rd_addr (lk_addr),
		.drd_data
	);

	cache_ctrl ctrl_i (
		.clk, .arst_n, .lk_valid, .lk_write, .lk_addr, .lk_wdata, .lk_hit,
		.drd_data, .mem_rvalid, .mem_rdata,
		.lk_take, .upd_en, .upd_index, .upd_tag, .upd_offset,
		.dwr_en, .dwr_index, .dwr_offset, .dwr_data,
		.mem_rd, .mem_wr, .mem_addr, .mem_wdata,
		.rsp_valid, .rsp_data, .rsp_hit
	);

	main_mem main_mem_i (
		.clk, .arst_n, .mem_rd, .mem_wr, .mem_addr, .mem_wdata,
		.mem_rvalid, .mem_rdata
	);

endmodule

`default_nettype wire

//--- list.f
cache_pkg.sv
cache_req_queue.sv
cache_tag_store.sv
cache_data_store.sv
cache_ctrl.sv
main_mem.sv
cache_top.sv
cache_properties.sv
tb_cache.sv

//--- main_mem.sv
`timescale 1ns/1ps
`default_nettype none

module main_mem (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 mem_rd,
	input  logic                 mem_wr,
	input  cache_pkg::mem_addr_t mem_addr,
	input  cache_pkg::word_t     mem_wdata,
	output logic                 mem_rvalid,
	output cache_pkg::word_t     mem_rdata
);
	import cache_pkg::*;

	word_t mem [MEM_WORDS];

	logic [MEM_LATENCY-1:0] rd_pipe;
	mem_addr_t              rd_addr_pipe [MEM_LATENCY];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_pipe <= '0;
		end else begin
			rd_pipe <= {rd_pipe[MEM_LATENCY-2:0], mem_rd};
		end
	end

	always_ff @(posedge clk) begin
		rd_addr_pipe[0] <= mem_addr;
		for (int i = 1; i < MEM_LATENCY; i++) begin
			rd_addr_pipe[i] <= rd_addr_pipe[i-1];
		end
	end

	always_ff @(posedge clk) begin
		if (mem_wr) begin
			mem[mem_addr] <= mem_wdata;
		end
	end

	// array read at the end of the delay line
	assign mem_rvalid = rd_pipe[MEM_LATENCY-1];
	assign mem_rdata  = mem[rd_addr_pipe[MEM_LATENCY-1]];

endmodule

`default_nettype wire

//--- tb_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache;
	import cache_pkg::*;

	localparam int WAIT_LIMIT = 200;

	logic  clk       = 1'b0;
	logic  arst_n    = 1'b0;
	logic  req_valid = 1'b0;
	logic  req_write = 1'b0;
	addr_t req_addr  = '0;
	word_t req_wdata = '0;
	logic  req_credit;
	logic  rsp_valid;
	word_t rsp_data;
	logic  rsp_hit;

	int               seed        = 32'h9190_78ad;
	int               credits     = QUEUE_DEPTH;
	int               min_credits = QUEUE_DEPTH;
	word_t            ref_mem [MEM_WORDS];
	tag_t             ref_tag [LINES]   = '{default: '0};
	logic [WORDS-1:0] ref_valid [LINES] = '{default: '0};
	word_t            exp_data [$];
	logic             exp_hit [$];

	cache_top cache_top_i (
		.clk, .arst_n, .req_valid, .req_write, .req_addr, .req_wdata,
		.req_credit, .rsp_valid, .rsp_data, .rsp_hit
	);

	bind cache_top cache_properties props_i (
		.clk, .arst_n, .rsp_valid, .req_credit, .mem_rd, .mem_wr, .state (ctrl_i.state)
	);

	always #2 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_equal(input word_t actual, input word_t expected, input string what);
		if (actual !== expected)
			abort_run($sformatf("CHECK FAILED at %0t: %s, got %h, expected %h",
				$time, what, actual, expected));
	endtask

	function automatic addr_t word_addr(input int index, input int tag, input int offset);
		return {3'(index), 5'(tag), 2'(offset), 2'b00};
	endfunction

	task automatic allocate(input addr_t a);
		if (ref_tag[a[11:9]] != a[8:4])
			ref_valid[a[11:9]] = '0; // tag change drops the siblings
		ref_valid[a[11:9]][a[3:2]] = 1'b1;
		ref_tag[a[11:9]] = a[8:4];
	endtask

	task automatic issue_req(input logic write, input addr_t a, input word_t d);
		int waited;
		waited = 0;
		@(negedge clk);
		req_valid = 1'b0;
		while (credits == 0) begin
			if (waited == WAIT_LIMIT)
				abort_run("timeout: the DUT returned no credit");
			waited++;
			@(negedge clk);
		end
		req_valid = 1'b1;
		req_write = write;
		req_addr  = a;
		req_wdata = d;
	endtask

	task automatic write_word(input addr_t a, input word_t d);
		ref_mem[a[11:2]] = d; // write-through
		allocate(a);
		issue_req(1'b1, a, d);
	endtask

	// want_hit below zero leaves the hit flag to the model alone
	task automatic read_word(input addr_t a, input int want_hit);
		logic hit;
		hit = ref_valid[a[11:9]][a[3:2]] && (ref_tag[a[11:9]] == a[8:4]);
		exp_data.push_back(ref_mem[a[11:2]]);
		exp_hit.push_back(want_hit < 0 ? hit : want_hit != 0);
		if (!hit)
			allocate(a);
		issue_req(1'b0, a, '0);
	endtask

	task automatic wait_drained();
		int waited;
		waited = 0;
		@(negedge clk);
		req_valid = 1'b0;
		while (exp_data.size() != 0 || credits != QUEUE_DEPTH) begin
			if (waited == WAIT_LIMIT)
				abort_run("timeout: reads or credits still outstanding");
			waited++;
			@(negedge clk);
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		req_valid = 1'b0;
		arst_n = 1'b0;
		exp_data.delete(); // reads in flight are dropped
		exp_hit.delete();
		repeat (4) @(negedge clk);
		arst_n = 1'b1;
		ref_valid = '{default: '0}; // tags and memory survive
	endtask

	always @(posedge clk) begin : credit_count
		if (!arst_n) begin
			credits = QUEUE_DEPTH;
		end else begin
			credits = credits - int'(req_valid) + int'(req_credit);
			check_equal(word_t'(credits < 0 || credits > QUEUE_DEPTH), '0, "credit count range");
			if (credits < min_credits)
				min_credits = credits;
		end
	end

	always @(posedge clk) begin : rsp_monitor
		word_t want_data;
		logic  want_hit;
		if (arst_n && rsp_valid) begin
			if (exp_data.size() == 0) begin
				abort_run("the DUT responded with no read outstanding");
			end else begin
				want_data = exp_data.pop_front();
				want_hit  = exp_hit.pop_front();
				check_equal(rsp_data, want_data, "read data");
				check_equal(word_t'(rsp_hit), word_t'(want_hit), "hit flag");
			end
		end
	end

	task automatic test_write_then_read();
		write_word(word_addr(1, 3, 2), $random(seed));
		read_word(word_addr(1, 3, 2), 1);
		wait_drained();
	endtask

	task automatic test_tag_conflict();
		write_word(word_addr(2, 4, 1), $random(seed));
		read_word(word_addr(2, 4, 1), 1);
		write_word(word_addr(2, 9, 3), $random(seed));
		read_word(word_addr(2, 4, 1), 0); // served from memory
		read_word(word_addr(2, 4, 1), 1);
		read_word(word_addr(2, 9, 3), 0);
		wait_drained();
	endtask

	task automatic test_sibling_valid();
		write_word(word_addr(5, 7, 2), $random(seed));
		write_word(word_addr(5, 1, 0), $random(seed));
		write_word(word_addr(5, 7, 0), $random(seed));
		read_word(word_addr(5, 7, 2), 0); // sibling bit was cleared
		read_word(word_addr(5, 7, 2), 1);
		read_word(word_addr(5, 7, 0), 1);
		wait_drained();
	endtask

	task automatic test_burst();
		int    r;
		addr_t a;
		min_credits = QUEUE_DEPTH;
		for (int i = 0; i < 32; i++)
			write_word(word_addr(i % 4, i < 16 ? 2 : 6, i / 4 % 4), $random(seed));
		for (int i = 0; i < 24; i++) begin
			r = $random(seed);
			a = word_addr(int'(r[1:0]), r[2] ? 6 : 2, int'(r[4:3]));
			if (r[7:5] == 3'd0)
				write_word(a, $random(seed));
			else
				read_word(a, -1);
		end
		read_word(a, -1); // last item a read, so every write has landed
		wait_drained();
		check_equal(word_t'(min_credits), '0, "burst never used up the credits");
	endtask

	task automatic test_reset_clears();
		for (int i = 0; i < 6; i++)
			read_word(word_addr(i % 4, 6, i / 4), -1); // still queued at reset
		apply_reset();
		@(negedge clk);
		check_equal(word_t'(credits), word_t'(QUEUE_DEPTH), "credits after reset");
		for (int i = 0; i < 32; i++)
			read_word(word_addr(i % 4, i < 16 ? 2 : 6, i / 4 % 4), 0);
		read_word(word_addr(3, 6, 3), 1);
		wait_drained();
	endtask

	initial begin
		apply_reset();
		test_write_then_read();
		test_tag_conflict();
		test_sibling_valid();
		test_burst();
		test_reset_clears();
		if (cache_top_i.props_i.assert_fails == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			abort_run("a bound assertion failed during the run");
		end
	end

endmodule

`default_nettype wire
